// ==== src/cache_pkg.sv ====
package cache_pkg;

    // address split
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    // geometry
    localparam int SETS   = 256;
    localparam int WAYS   = 2;
    localparam int BANKS  = 4;
    localparam int WORD_W = 32;
    localparam int LINE_W = 128;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [1:0]          bank_t;
    typedef logic                way_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [3:0]          strb_t;
    typedef logic [LINE_W-1:0]   line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } cache_state_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cpu_op_e;

    // whole-line burst on both memory ports
    localparam logic [2:0] LINE_BURST = 3'b100;
    localparam strb_t      FULL_STRB  = 4'b1111;

endpackage

// ==== src/cache_arrays.sv ====
`timescale 1ns/1ps

module cache_arrays
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   rd_en,
    input  index_t rd_index,
    input  index_t wr_index,
    input  logic   data_we,
    input  way_t   wr_way,
    input  bank_t  wr_bank,
    input  strb_t  wr_strb,
    input  word_t  wr_word,
    input  logic   tag_we,
    input  tag_t   new_tag,
    input  logic   dirty_we,
    input  logic   dirty_value,
    output tag_t   way_tag   [WAYS],
    output logic   way_valid [WAYS],
    output logic   way_dirty [WAYS],
    output line_t  way_line  [WAYS],
    output way_t   victim_way
);

    tag_t            tag_mem    [WAYS][SETS];
    word_t           bank_mem   [WAYS][BANKS][SETS];
    logic [SETS-1:0] valid_bits [WAYS];
    logic [SETS-1:0] dirty_bits [WAYS];
    logic [SETS-1:0] rr_bits;
    index_t          last_index;

    // status bits, cleared on reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
                way_valid[w]  <= 1'b0;
                way_dirty[w]  <= 1'b0;
            end
            rr_bits <= '0;
        end else begin
            if (tag_we) begin
                valid_bits[wr_way][wr_index] <= 1'b1;
                // one tag write per refill, so one flip per refill
                rr_bits[wr_index] <= ~rr_bits[wr_index];
            end
            if (dirty_we) begin
                dirty_bits[wr_way][wr_index] <= dirty_value;
            end
            if (rd_en) begin
                for (int w = 0; w < WAYS; w++) begin
                    way_valid[w] <= valid_bits[w][rd_index];
                    way_dirty[w] <= dirty_bits[w][rd_index];
                end
            end
        end
    end

    // tag and data writes
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[wr_way][wr_index] <= new_tag;
        end
        if (data_we) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (wr_strb[b]) begin
                    bank_mem[wr_way][wr_bank][wr_index][b*8 +: 8] <= wr_word[b*8 +: 8];
                end
            end
        end
    end

    // synchronous read, held until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            last_index <= rd_index;
            for (int w = 0; w < WAYS; w++) begin
                way_tag[w] <= tag_mem[w][rd_index];
                for (int k = 0; k < BANKS; k++) begin
                    way_line[w][k*WORD_W +: WORD_W] <= bank_mem[w][k][rd_index];
                end
            end
        end
    end

    // empty way first, then round robin
    always_comb begin
        if (!way_valid[0]) begin
            victim_way = 1'b0;
        end else if (!way_valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = rr_bits[last_index];
        end
    end

endmodule

// ==== src/lookup_ctrl.sv ====
`timescale 1ns/1ps

module lookup_ctrl
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    // cpu side
    input  logic        valid,
    input  cpu_op_e     op,
    input  index_t      index,
    input  tag_t        tag,
    input  offset_t     offset,
    input  strb_t       wstrb,
    input  word_t       wdata,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t       rdata,
    // read port
    output logic        rd_req,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  word_t       ret_data,
    // arrays
    input  tag_t        way_tag   [WAYS],
    input  logic        way_valid [WAYS],
    input  line_t       way_line  [WAYS],
    input  way_t        victim_way,
    output logic        rd_en,
    output index_t      rd_index,
    output index_t      wr_index,
    output logic        data_we,
    output way_t        wr_way,
    output bank_t       wr_bank,
    output strb_t       wr_strb,
    output word_t       wr_word,
    output logic        tag_we,
    output tag_t        new_tag,
    output logic        dirty_we,
    output logic        dirty_value,
    // victim writer
    input  logic        busy,
    output logic        capture,
    output index_t      miss_index
);

    cache_state_e state;
    cache_state_e next_state;

    cpu_op_e req_op;
    index_t  req_index;
    tag_t    req_tag;
    offset_t req_offset;
    strb_t   req_wstrb;
    word_t   req_wdata;

    bank_t      req_bank;
    logic [1:0] way_hit;
    logic       cache_hit;
    way_t       hit_way;
    line_t      hit_line;
    word_t      hit_word;
    bank_t      refill_cnt;
    way_t       repl_way;
    word_t      fill_word;
    logic       accept;
    logic       hit_write;
    logic       fill_beat;

    assign accept    = (state == IDLE) && valid;
    assign fill_beat = (state == REFILL) && ret_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (valid) next_state = LOOKUP;
            LOOKUP:  next_state = cache_hit ? IDLE : MISS;
            // hold off while an earlier victim is still draining
            MISS:    if (!busy) next_state = REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (ret_valid && ret_last) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op     <= op;
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    assign req_bank = req_offset[OFFSET_W-1:2];

    // tag compare on the data read in IDLE
    assign way_hit[0] = way_valid[0] && (way_tag[0] == req_tag);
    assign way_hit[1] = way_valid[1] && (way_tag[1] == req_tag);
    assign cache_hit  = |way_hit;
    assign hit_way    = way_hit[1];
    assign hit_line   = way_line[hit_way];
    assign hit_word   = hit_line[req_bank*WORD_W +: WORD_W];
    assign hit_write  = (state == LOOKUP) && cache_hit && (req_op == OP_WRITE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            refill_cnt <= '0;
            repl_way   <= 1'b0;
        end else begin
            if (capture) begin
                repl_way <= victim_way;
            end
            if (fill_beat) begin
                refill_cnt <= ret_last ? bank_t'(0) : refill_cnt + 1'b1;
            end
        end
    end

    // write miss merges its bytes into its own beat
    always_comb begin
        fill_word = ret_data;
        if (req_op == OP_WRITE && refill_cnt == req_bank) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (req_wstrb[b]) begin
                    fill_word[b*8 +: 8] = req_wdata[b*8 +: 8];
                end
            end
        end
    end

    assign addr_ok = (state == IDLE);
    assign data_ok = ((state == LOOKUP) && (cache_hit || req_op == OP_WRITE)) ||
                     (fill_beat && refill_cnt == req_bank && req_op == OP_READ);
    assign rdata   = (state == REFILL) ? ret_data : hit_word;

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

    assign rd_en    = accept;
    assign rd_index = index;

    assign wr_index    = req_index;
    assign data_we     = hit_write || fill_beat;
    assign wr_way      = (state == REFILL) ? repl_way : hit_way;
    assign wr_bank     = (state == REFILL) ? refill_cnt : req_bank;
    assign wr_strb     = (state == REFILL) ? FULL_STRB : req_wstrb;
    assign wr_word     = (state == REFILL) ? fill_word : req_wdata;
    assign tag_we      = fill_beat && ret_last;
    assign new_tag     = req_tag;
    assign dirty_we    = hit_write || tag_we;
    assign dirty_value = (req_op == OP_WRITE);

    assign capture    = (state == MISS) && !busy;
    assign miss_index = req_index;

endmodule

// ==== src/victim_writer.sv ====
`timescale 1ns/1ps

module victim_writer
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        capture,
    input  index_t      miss_index,
    input  way_t        victim_way,
    input  tag_t        way_tag   [WAYS],
    input  logic        way_dirty [WAYS],
    input  line_t       way_line  [WAYS],
    input  logic        wr_rdy,
    output logic        wr_req,
    output logic [31:0] wr_addr,
    output line_t       wr_data,
    output logic        busy
);

    logic pending;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= 1'b0;
        end else if (capture) begin
            // clean victims need no write-back
            pending <= way_dirty[victim_way];
        end else if (pending && wr_rdy) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            wr_data <= way_line[victim_way];
            wr_addr <= {way_tag[victim_way], miss_index, {OFFSET_W{1'b0}}};
        end
    end

    assign wr_req = pending;
    assign busy   = pending;

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    // cpu side
    input  logic         valid,
    input  cpu_op_e      op,
    input  index_t       index,
    input  tag_t         tag,
    input  offset_t      offset,
    input  strb_t        wstrb,
    input  word_t        wdata,
    output logic         addr_ok,
    output logic         data_ok,
    output word_t        rdata,
    // memory read port
    output logic         rd_req,
    output logic [2:0]   rd_type,
    output logic [31:0]  rd_addr,
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  logic         ret_last,
    input  word_t        ret_data,
    // memory write port
    output logic         wr_req,
    output logic [2:0]   wr_type,
    output logic [31:0]  wr_addr,
    output strb_t        wr_wstrb,
    output line_t        wr_data,
    input  logic         wr_rdy
);

    tag_t   way_tag   [WAYS];
    logic   way_valid [WAYS];
    logic   way_dirty [WAYS];
    line_t  way_line  [WAYS];
    way_t   victim_way;
    logic   rd_en;
    index_t rd_index;
    index_t wr_index;
    logic   data_we;
    way_t   wr_way;
    bank_t  wr_bank;
    strb_t  wr_strb;
    word_t  wr_word;
    logic   tag_we;
    tag_t   new_tag;
    logic   dirty_we;
    logic   dirty_value;
    logic   capture;
    logic   busy;
    index_t miss_index;

    lookup_ctrl u_lookup_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .op          (op),
        .index       (index),
        .tag         (tag),
        .offset      (offset),
        .wstrb       (wstrb),
        .wdata       (wdata),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .way_tag     (way_tag),
        .way_valid   (way_valid),
        .way_line    (way_line),
        .victim_way  (victim_way),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .wr_index    (wr_index),
        .data_we     (data_we),
        .wr_way      (wr_way),
        .wr_bank     (wr_bank),
        .wr_strb     (wr_strb),
        .wr_word     (wr_word),
        .tag_we      (tag_we),
        .new_tag     (new_tag),
        .dirty_we    (dirty_we),
        .dirty_value (dirty_value),
        .busy        (busy),
        .capture     (capture),
        .miss_index  (miss_index)
    );

    cache_arrays u_cache_arrays (
        .clk         (clk),
        .resetn      (resetn),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .wr_index    (wr_index),
        .data_we     (data_we),
        .wr_way      (wr_way),
        .wr_bank     (wr_bank),
        .wr_strb     (wr_strb),
        .wr_word     (wr_word),
        .tag_we      (tag_we),
        .new_tag     (new_tag),
        .dirty_we    (dirty_we),
        .dirty_value (dirty_value),
        .way_tag     (way_tag),
        .way_valid   (way_valid),
        .way_dirty   (way_dirty),
        .way_line    (way_line),
        .victim_way  (victim_way)
    );

    victim_writer u_victim_writer (
        .clk        (clk),
        .resetn     (resetn),
        .capture    (capture),
        .miss_index (miss_index),
        .victim_way (victim_way),
        .way_tag    (way_tag),
        .way_dirty  (way_dirty),
        .way_line   (way_line),
        .wr_rdy     (wr_rdy),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .busy       (busy)
    );

    assign rd_type  = LINE_BURST;
    assign wr_type  = LINE_BURST;
    assign wr_wstrb = FULL_STRB;

endmodule

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam int RESET_CYCLES = 10;

    typedef struct {
        cpu_op_e     op;
        logic [31:0] addr;
        strb_t       strb;
        word_t       data;
        bit          hit;
        bit          wb;
    } entry_t;

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_op_e     op;
    index_t      index;
    tag_t        tag;
    offset_t     offset;
    strb_t       wstrb;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [2:0]  rd_type;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    logic [2:0]  wr_type;
    logic [31:0] wr_addr;
    strb_t       wr_wstrb;
    line_t       wr_data;
    logic        wr_rdy;

    entry_t      entries[$];
    word_t       mem_words [logic [29:0]];
    word_t       shadow    [logic [29:0]];
    int          errors;
    int          cycles;
    int          cycle_limit;
    logic [31:0] cur_addr;
    logic [31:0] wb_addr;
    logic        rd_seen;
    logic        wr_seen;

    cache_top dut (
        .clk(clk), .resetn(resetn), .valid(valid), .op(op), .index(index), .tag(tag),
        .offset(offset), .wstrb(wstrb), .wdata(wdata), .addr_ok(addr_ok),
        .data_ok(data_ok), .rdata(rdata), .rd_req(rd_req), .rd_type(rd_type),
        .rd_addr(rd_addr), .rd_rdy(rd_rdy), .ret_valid(ret_valid), .ret_last(ret_last),
        .ret_data(ret_data), .wr_req(wr_req), .wr_type(wr_type), .wr_addr(wr_addr),
        .wr_wstrb(wr_wstrb), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // untouched memory words follow the whole address
    function automatic word_t rule_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5A3C_96E1;
    endfunction

    function automatic word_t mem_read(input logic [31:0] a);
        if (mem_words.exists(a[31:2])) begin
            return mem_words[a[31:2]];
        end
        return rule_word(a);
    endfunction

    function automatic word_t shadow_read(input logic [31:0] a);
        if (shadow.exists(a[31:2])) begin
            return shadow[a[31:2]];
        end
        return rule_word(a);
    endfunction

    function automatic void shadow_write(input logic [31:0] a, input strb_t s, input word_t d);
        word_t w;
        w = shadow_read(a);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        shadow[a[31:2]] = w;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input logic [31:0] mask);
        if ((got & mask) !== (exp & mask)) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name,
                     got & mask, exp & mask);
            errors++;
        end
    endtask

    function automatic void add_entry(input cpu_op_e o, input logic [31:0] a, input strb_t s,
                                      input word_t d, input bit hit, input bit wb);
        entry_t e;
        e.op   = o;
        e.addr = a;
        e.strb = s;
        e.data = d;
        e.hit  = hit;
        e.wb   = wb;
        entries.push_back(e);
    endfunction

    // set 5 takes tags 1, 2, 3 and set 9 tags 4, 5, 6
    function automatic void load_table();
        add_entry(OP_READ,  32'h1000_0054, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry(OP_READ,  32'h1000_0054, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_READ,  32'h1000_005C, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_WRITE, 32'h1000_0058, 4'h3, 32'hDEAD_BEEF, 1'b1, 1'b0);
        add_entry(OP_READ,  32'h1000_0058, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_WRITE, 32'h2000_0054, 4'hC, 32'hCAFE_1234, 1'b0, 1'b0);
        add_entry(OP_READ,  32'h2000_0054, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_READ,  32'h2000_0050, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_READ,  32'h2000_005C, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_WRITE, 32'h3000_0050, 4'hF, 32'h0BAD_F00D, 1'b0, 1'b1);
        add_entry(OP_READ,  32'h3000_0050, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_READ,  32'h1000_0058, 4'h0, 32'h0, 1'b0, 1'b1);
        add_entry(OP_READ,  32'h1000_0050, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_READ,  32'h2000_0054, 4'h0, 32'h0, 1'b0, 1'b1);
        add_entry(OP_READ,  32'h4000_0090, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry(OP_READ,  32'h5000_0094, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry(OP_READ,  32'h6000_0098, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry(OP_READ,  32'h4000_009C, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry(OP_READ,  32'h1000_0058, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_WRITE, 32'h4000_009C, 4'h4, 32'h00AB_0000, 1'b1, 1'b0);
        add_entry(OP_READ,  32'h4000_009C, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry(OP_READ,  32'h7000_0A08, 4'h0, 32'h0, 1'b0, 1'b0);
    endfunction

    task automatic run_entry(input int i);
        entry_t e;
        int     lat;
        int     err_before;
        word_t  got;
        e = entries[i];
        err_before = errors;
        while (!addr_ok) @(negedge clk);
        cur_addr = e.addr;
        rd_seen  = 1'b0;
        wr_seen  = 1'b0;
        valid    = 1'b1;
        op       = e.op;
        tag      = e.addr[31:12];
        index    = e.addr[11:4];
        offset   = e.addr[3:0];
        wstrb    = e.strb;
        wdata    = e.data;
        @(negedge clk);
        valid = 1'b0;
        lat = 1;
        // data_ok can follow a beat driven on this same edge
        #5;
        while (!data_ok) begin
            @(negedge clk);
            #5;
            lat++;
        end
        got = rdata;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        if (e.op == OP_WRITE) begin
            shadow_write(e.addr, e.strb, e.data);
        end else begin
            check_word("rdata", got, shadow_read(e.addr));
        end
        if (e.hit && (lat != 1 || rd_seen)) begin
            report_error($sformatf("expected a hit, latency %0d, rd_req %0b", lat, rd_seen));
        end
        if (!e.hit && !rd_seen) begin
            report_error("expected a miss but no rd_req was raised");
        end
        if (e.wb && !wr_seen) begin
            report_error("expected a dirty write-back but wr_req never rose");
        end else if (e.wb) begin
            check_addr("wr_addr", wb_addr, {20'h0, e.addr[11:4], 4'h0}, 32'h0000_0FFF);
        end
        if (!e.wb && wr_seen) begin
            report_error("unexpected write-back of a clean or empty line");
        end
        $display("test %0d: %s addr %h %s", i, e.op.name(), e.addr,
                 (errors == err_before) ? "ok" : "wrong");
    endtask

    // read port, one line burst at a time
    initial begin : read_port_model
        logic [31:0] line_addr;
        forever begin
            @(negedge clk);
            if (resetn && rd_req) begin
                rd_seen = 1'b1;
                line_addr = rd_addr;
                check_addr("rd_addr", rd_addr, {cur_addr[31:4], 4'h0}, 32'hFFFF_FFFF);
                repeat ($urandom_range(3, 0)) @(negedge clk);
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int k = 0; k < BANKS; k++) begin
                    repeat ($urandom_range(3, 0)) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last  = (k == BANKS - 1);
                    ret_data  = mem_read(line_addr + 32'(4 * k));
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    // write port, line lands in memory as wr_rdy goes out
    initial begin : write_port_model
        forever begin
            @(negedge clk);
            if (resetn && wr_req) begin
                wr_seen = 1'b1;
                wb_addr = wr_addr;
                repeat ($urandom_range(3, 0)) @(negedge clk);
                wr_rdy = 1'b1;
                for (int k = 0; k < BANKS; k++) begin
                    mem_words[wr_addr[31:2] + 30'(k)] = wr_data[k*WORD_W +: WORD_W];
                end
                @(negedge clk);
                wr_rdy = 1'b0;
            end
        end
    end

    initial begin : stimulus
        clk       = 1'b0;
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = OP_READ;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        errors    = 0;
        cycles    = 0;
        cur_addr  = '0;
        wb_addr   = '0;
        rd_seen   = 1'b0;
        wr_seen   = 1'b0;
        void'($urandom(33));
        load_table();
        cycle_limit = entries.size() * 40 + RESET_CYCLES;
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        if (rd_type !== LINE_BURST || wr_type !== LINE_BURST || wr_wstrb !== FULL_STRB) begin
            report_error("burst type or write strobe outputs are not the line-burst constants");
        end
        for (int i = 0; i < entries.size(); i++) begin
            run_entry(i);
        end
        $display("%0d tests run, %0d errors", entries.size(), errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/cache_pkg.sv
src/cache_arrays.sv
src/lookup_ctrl.sv
src/victim_writer.sv
src/cache_top.sv
test/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator, pass only on the pass line in sim.log
rm -f sim.log \
    && verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
        --top-module cache_tb -f list.f -o cache_sim \
    && ./obj_dir/cache_sim | tee sim.log \
    && grep -qx "All tests passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
